// ==== hw/simd_alu_pkg.sv ====
package simd_alu_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  parameter int unsigned LaneBits  = 64;
  parameter int unsigned LaneBytes = LaneBits / 8;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } elem_width_e;

  typedef enum logic [4:0] {
    // Bitwise
    OP_AND, OP_OR, OP_XOR,
    // Wrapping arithmetic
    OP_ADD, OP_SUB,
    // Saturating arithmetic
    OP_SADDU, OP_SADD, OP_SSUBU, OP_SSUB,
    // Min and max
    OP_MINU, OP_MIN, OP_MAXU, OP_MAX,
    // Mask compares, outcome in the element LSB
    OP_MSEQ, OP_MSNE,
    OP_MSLTU, OP_MSLT,
    OP_MSLEU, OP_MSLE,
    OP_MSGTU, OP_MSGT,
    // Shifts
    OP_SLL, OP_SRL, OP_SRA
  } alu_op_e;

  // Datapath selected by decode
  typedef enum logic [2:0] {
    CLS_LOGIC  = 3'd0,
    CLS_ADD    = 3'd1,
    CLS_SUB    = 3'd2,
    CLS_MINMAX = 3'd3,
    CLS_CMP    = 3'd4,
    CLS_SHIFT  = 3'd5
  } op_class_e;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Byte positions holding an element base within one lane
  function automatic logic [LaneBytes-1:0] elem_base_mask(elem_width_e vew);
    case (vew)
      EW8:     return 8'hff;
      EW16:    return 8'h55;
      EW32:    return 8'h11;
      default: return 8'h01;
    endcase
  endfunction

endpackage

// ==== hw/simd_alu_decode.sv ====
module simd_alu_decode #(
  parameter int unsigned DataWidth = 64
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::elem_width_e vew_i,
  input  logic [DataWidth-1:0]      operand_a_i,
  input  logic [DataWidth-1:0]      operand_b_i,
  output logic                      valid_o,
  output simd_alu_pkg::alu_op_e     op_o,
  output simd_alu_pkg::elem_width_e vew_o,
  output simd_alu_pkg::op_class_e   class_o,
  output logic                      signed_o,
  output logic [DataWidth-1:0]      opa_o,
  output logic [DataWidth-1:0]      opb_o
);
  import simd_alu_pkg::*;

  op_class_e op_class;
  logic      op_signed;

  always_comb begin
    op_class = CLS_LOGIC;
    case (op_i)
      OP_ADD, OP_SADDU, OP_SADD:       op_class = CLS_ADD;
      OP_SUB, OP_SSUBU, OP_SSUB:       op_class = CLS_SUB;
      OP_MINU, OP_MIN, OP_MAXU, OP_MAX: op_class = CLS_MINMAX;
      OP_MSEQ, OP_MSNE,
      OP_MSLTU, OP_MSLT,
      OP_MSLEU, OP_MSLE,
      OP_MSGTU, OP_MSGT:               op_class = CLS_CMP;
      OP_SLL, OP_SRL, OP_SRA:          op_class = CLS_SHIFT;
      default:                         op_class = CLS_LOGIC;
    endcase
  end

  // Only the compare stage needs this; saturation reads the opcode itself
  assign op_signed = op_i inside {OP_MIN, OP_MAX, OP_MSLT, OP_MSLE, OP_MSGT};

  //////////////////////////////
  // Stage register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      op_o     <= op_i;
      vew_o    <= vew_i;
      class_o  <= op_class;
      signed_o <= op_signed;
      opa_o    <= operand_a_i;
      opb_o    <= operand_b_i;
    end
  end

  a_op_defined: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> !$isunknown(op_i) && (op_i inside {[OP_AND:OP_SRA]}))
    else $error("undefined opcode %0d accepted", op_i);

endmodule

// ==== hw/simd_alu_compare.sv ====
module simd_alu_compare #(
  parameter int unsigned DataWidth = 64
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::elem_width_e vew_i,
  input  simd_alu_pkg::op_class_e   class_i,
  input  logic                      signed_i,
  input  logic [DataWidth-1:0]      opa_i,
  input  logic [DataWidth-1:0]      opb_i,
  output logic                      valid_o,
  output simd_alu_pkg::alu_op_e     op_o,
  output simd_alu_pkg::elem_width_e vew_o,
  output simd_alu_pkg::op_class_e   class_o,
  output logic [DataWidth-1:0]      opa_o,
  output logic [DataWidth-1:0]      opb_o,
  output logic [DataWidth/8-1:0]    less_o,
  output logic [DataWidth/8-1:0]    equal_o
);
  import simd_alu_pkg::*;

  localparam int unsigned NumLanes = DataWidth / LaneBits;

  logic [DataWidth/8-1:0] less_d;
  logic [DataWidth/8-1:0] equal_d;

  //////////////////////////////
  // Per element compare
  //////////////////////////////

  for (genvar l = 0; l < NumLanes; l++) begin : g_lane
    // One candidate vector per element width
    logic [3:0][LaneBytes-1:0] less_w;
    logic [3:0][LaneBytes-1:0] equal_w;

    for (genvar k = 0; k < 4; k++) begin : g_width
      localparam int unsigned Ew = 8 << k;
      localparam int unsigned Nb = Ew / 8;
      localparam int unsigned Ne = LaneBits / Ew;

      for (genvar e = 0; e < Ne; e++) begin : g_elem
        logic [Ew-1:0] a;
        logic [Ew-1:0] b;
        logic          lt;

        assign a = opa_i[l*LaneBits + e*Ew +: Ew];
        assign b = opb_i[l*LaneBits + e*Ew +: Ew];

        // Extra top bit turns one signed compare into both kinds
        assign lt = $signed({signed_i & b[Ew-1], b}) < $signed({signed_i & a[Ew-1], a});

        assign less_w[k][e*Nb +: Nb]  = Nb'(lt);
        assign equal_w[k][e*Nb +: Nb] = Nb'(a == b);
      end
    end

    assign less_d[l*LaneBytes +: LaneBytes]  = less_w[vew_i];
    assign equal_d[l*LaneBytes +: LaneBytes] = equal_w[vew_i];
  end

  //////////////////////////////
  // Stage register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      op_o    <= op_i;
      vew_o   <= vew_i;
      class_o <= class_i;
      opa_o   <= opa_i;
      opb_o   <= opb_i;
      less_o  <= less_d;
      equal_o <= equal_d;
    end
  end

  a_less_on_base: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> (less_o & ~{NumLanes{elem_base_mask(vew_o)}}) == '0)
    else $error("less bit set off an element base");

endmodule

// ==== hw/simd_alu_execute.sv ====
module simd_alu_execute #(
  parameter int unsigned DataWidth = 64
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::elem_width_e vew_i,
  input  simd_alu_pkg::op_class_e   class_i,
  input  logic [DataWidth-1:0]      opa_i,
  input  logic [DataWidth-1:0]      opb_i,
  input  logic [DataWidth/8-1:0]    less_i,
  input  logic [DataWidth/8-1:0]    equal_i,
  output logic                      valid_o,
  output logic [DataWidth-1:0]      result_o,
  output logic [DataWidth/8-1:0]    vxsat_o
);
  import simd_alu_pkg::*;

  localparam int unsigned NumLanes = DataWidth / LaneBits;

  logic [DataWidth-1:0]   logic_res;
  logic [DataWidth-1:0]   arith_res;
  logic [DataWidth-1:0]   result_d;
  logic [DataWidth/8-1:0] vxsat_d;
  logic                   is_max;

  // Bitwise ops ignore element boundaries
  always_comb begin
    case (op_i)
      OP_AND:  logic_res = opa_i & opb_i;
      OP_OR:   logic_res = opa_i | opb_i;
      default: logic_res = opa_i ^ opb_i;
    endcase
  end

  assign is_max = op_i inside {OP_MAXU, OP_MAX};

  //////////////////////////////
  // Per element datapath
  //////////////////////////////

  for (genvar l = 0; l < NumLanes; l++) begin : g_lane
    logic [3:0][LaneBits-1:0]  res_w;
    logic [3:0][LaneBytes-1:0] sat_w;

    for (genvar k = 0; k < 4; k++) begin : g_width
      localparam int unsigned Ew = 8 << k;
      localparam int unsigned Nb = Ew / 8;
      localparam int unsigned Ne = LaneBits / Ew;
      localparam int unsigned Sw = $clog2(Ew);
      localparam logic [Ew-1:0] MaxS = {1'b0, {(Ew-1){1'b1}}};
      localparam logic [Ew-1:0] MinS = {1'b1, {(Ew-1){1'b0}}};

      for (genvar e = 0; e < Ne; e++) begin : g_elem
        logic [Ew-1:0] a;
        logic [Ew-1:0] b;
        logic [Ew-1:0] res;
        logic [Ew:0]   sum;
        logic [Ew:0]   dif;
        logic [Sw-1:0] shamt;
        logic          lt;
        logic          eq;
        logic          add_ovf;
        logic          sub_ovf;
        logic          sat;

        assign a     = opa_i[l*LaneBits + e*Ew +: Ew];
        assign b     = opb_i[l*LaneBits + e*Ew +: Ew];
        assign lt    = less_i[l*LaneBytes + e*Nb];
        assign eq    = equal_i[l*LaneBytes + e*Nb];
        assign shamt = a[Sw-1:0];

        // Widened by one bit for the unsigned carry and borrow
        assign sum = {1'b0, a} + {1'b0, b};
        assign dif = {1'b0, b} - {1'b0, a};

        // Signed overflow when the result sign disagrees with the inputs
        assign add_ovf = (a[Ew-1] == b[Ew-1]) && (sum[Ew-1] != a[Ew-1]);
        assign sub_ovf = (a[Ew-1] != b[Ew-1]) && (dif[Ew-1] != b[Ew-1]);

        always_comb begin
          res = '0;
          sat = 1'b0;
          case (class_i)
            CLS_ADD: begin
              res = sum[Ew-1:0];
              if (op_i == OP_SADDU && sum[Ew]) begin
                res = '1;
                sat = 1'b1;
              end else if (op_i == OP_SADD && add_ovf) begin
                res = a[Ew-1] ? MinS : MaxS;
                sat = 1'b1;
              end
            end
            CLS_SUB: begin
              res = dif[Ew-1:0];
              if (op_i == OP_SSUBU && dif[Ew]) begin
                res = '0;
                sat = 1'b1;
              end else if (op_i == OP_SSUB && sub_ovf) begin
                res = b[Ew-1] ? MinS : MaxS;
                sat = 1'b1;
              end
            end
            CLS_MINMAX: res = (lt ^ is_max) ? b : a;
            CLS_CMP: begin
              case (op_i)
                OP_MSEQ:           res = Ew'(eq);
                OP_MSNE:           res = Ew'(!eq);
                OP_MSLTU, OP_MSLT: res = Ew'(lt);
                OP_MSLEU, OP_MSLE: res = Ew'(lt | eq);
                default:           res = Ew'(!(lt | eq));
              endcase
            end
            CLS_SHIFT: begin
              case (op_i)
                OP_SLL:  res = b << shamt;
                OP_SRL:  res = b >> shamt;
                default: res = $signed(b) >>> shamt;
              endcase
            end
            default: res = '0;
          endcase
        end

        assign res_w[k][e*Ew +: Ew] = res;
        // Flag copied to every byte of the element
        assign sat_w[k][e*Nb +: Nb] = {Nb{sat}};
      end
    end

    assign arith_res[l*LaneBits +: LaneBits] = res_w[vew_i];
    assign vxsat_d[l*LaneBytes +: LaneBytes] = sat_w[vew_i];
  end

  assign result_d = (class_i == CLS_LOGIC) ? logic_res : arith_res;

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      vxsat_o  <= '0;
    end else begin
      valid_o <= valid_i;
      // Flags only qualify a valid result
      vxsat_o <= valid_i ? vxsat_d : '0;
      if (valid_i) begin
        result_o <= result_d;
      end
    end
  end

  a_flags_need_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !valid_o |-> vxsat_o == '0)
    else $error("saturation flags raised without a valid result");

endmodule

// ==== hw/simd_alu.sv ====
module simd_alu #(
  parameter int unsigned DataWidth = 64
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      valid_i,
  input  simd_alu_pkg::alu_op_e     op_i,
  input  simd_alu_pkg::elem_width_e vew_i,
  input  logic [DataWidth-1:0]      operand_a_i,
  input  logic [DataWidth-1:0]      operand_b_i,
  output logic                      valid_o,
  output logic [DataWidth-1:0]      result_o,
  output logic [DataWidth/8-1:0]    vxsat_o
);
  import simd_alu_pkg::*;

  // Decode to compare
  logic                 dec_valid;
  alu_op_e              dec_op;
  elem_width_e          dec_vew;
  op_class_e            dec_class;
  logic                 dec_signed;
  logic [DataWidth-1:0] dec_opa;
  logic [DataWidth-1:0] dec_opb;

  // Compare to execute
  logic                   cmp_valid;
  alu_op_e                cmp_op;
  elem_width_e            cmp_vew;
  op_class_e              cmp_class;
  logic [DataWidth-1:0]   cmp_opa;
  logic [DataWidth-1:0]   cmp_opb;
  logic [DataWidth/8-1:0] cmp_less;
  logic [DataWidth/8-1:0] cmp_equal;

  if (DataWidth % LaneBits != 0 || DataWidth == 0) begin : g_width_check
    $error("DataWidth must be a nonzero multiple of %0d", LaneBits);
  end

  //////////////////////////////
  // Pipeline
  //////////////////////////////

  simd_alu_decode #(
    .DataWidth (DataWidth)
  ) u_decode (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .vew_i       (vew_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (dec_valid),
    .op_o        (dec_op),
    .vew_o       (dec_vew),
    .class_o     (dec_class),
    .signed_o    (dec_signed),
    .opa_o       (dec_opa),
    .opb_o       (dec_opb)
  );

  simd_alu_compare #(
    .DataWidth (DataWidth)
  ) u_compare (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (dec_valid),
    .op_i     (dec_op),
    .vew_i    (dec_vew),
    .class_i  (dec_class),
    .signed_i (dec_signed),
    .opa_i    (dec_opa),
    .opb_i    (dec_opb),
    .valid_o  (cmp_valid),
    .op_o     (cmp_op),
    .vew_o    (cmp_vew),
    .class_o  (cmp_class),
    .opa_o    (cmp_opa),
    .opb_o    (cmp_opb),
    .less_o   (cmp_less),
    .equal_o  (cmp_equal)
  );

  simd_alu_execute #(
    .DataWidth (DataWidth)
  ) u_execute (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (cmp_valid),
    .op_i     (cmp_op),
    .vew_i    (cmp_vew),
    .class_i  (cmp_class),
    .opa_i    (cmp_opa),
    .opb_i    (cmp_opb),
    .less_i   (cmp_less),
    .equal_i  (cmp_equal),
    .valid_o  (valid_o),
    .result_o (result_o),
    .vxsat_o  (vxsat_o)
  );

endmodule

// ==== sim/simd_alu_vectors.svh ====
`ifndef SIMD_ALU_VECTORS_SVH
`define SIMD_ALU_VECTORS_SVH

task automatic load_vectors();
  // Name, op, width, then a, b, expected result, expected flags
  add_vector("and_ew64", OP_AND, EW64,
    64'hff00_ff00_f0f0_1234, 64'h0ff0_0ff0_ffff_ff00, 64'h0f00_0f00_f0f0_1200, 8'h00);
  add_vector("or_ew8", OP_OR, EW8,
    64'h0102_0408_1020_4080, 64'h8040_2010_0804_0201, 64'h8142_2418_1824_4281, 8'h00);
  add_vector("xor_ew16", OP_XOR, EW16,
    64'haaaa_5555_ffff_0000, 64'h5555_5555_0f0f_1234, 64'hffff_0000_f0f0_1234, 8'h00);
  // Carries and borrows stay inside each element
  add_vector("add_ew8", OP_ADD, EW8,
    64'h01ff_8080_7f01_00ff, 64'h0101_8080_0101_0001, 64'h0200_0000_8002_0000, 8'h00);
  add_vector("add_ew16", OP_ADD, EW16,
    64'hffff_1234_8000_0001, 64'h0001_1111_8000_ffff, 64'h0000_2345_0000_0000, 8'h00);
  add_vector("add_ew32", OP_ADD, EW32,
    64'hffff_ffff_8000_0001, 64'h0000_0001_8000_ffff, 64'h0000_0000_0001_0000, 8'h00);
  add_vector("add_ew64", OP_ADD, EW64,
    64'hffff_ffff_ffff_ffff, 64'h0000_0000_0000_0002, 64'h0000_0000_0000_0001, 8'h00);
  add_vector("sub_ew8", OP_SUB, EW8,
    64'h0101_0200_ff10_0080, 64'h0005_0100_0020_7f00, 64'hff04_ff00_0110_7f80, 8'h00);
  add_vector("sub_ew16", OP_SUB, EW16,
    64'h0001_8000_0000_1234, 64'h0000_7fff_0001_0234, 64'hffff_ffff_0001_f000, 8'h00);
  add_vector("sub_ew32", OP_SUB, EW32,
    64'h0000_0001_0000_0002, 64'h8000_0000_0000_0001, 64'h7fff_ffff_ffff_ffff, 8'h00);
  add_vector("sub_ew64", OP_SUB, EW64,
    64'h0000_0000_0000_0001, 64'h0000_0001_0000_0000, 64'h0000_0000_ffff_ffff, 8'h00);
  // Saturation flags cover every byte of a clamped element
  add_vector("saddu_ew8", OP_SADDU, EW8,
    64'h8001_ff00_7f10_c001, 64'h8001_0100_80f0_40fe, 64'hff02_ff00_ffff_ffff, 8'ha6);
  add_vector("sadd_ew16", OP_SADD, EW16,
    64'h7fff_8000_1234_ffff, 64'h0001_ffff_1111_ffff, 64'h7fff_8000_2345_fffe, 8'hf0);
  add_vector("ssubu_ew32", OP_SSUBU, EW32,
    64'h0000_0002_0000_0001, 64'h0000_0001_ffff_ffff, 64'h0000_0000_ffff_fffe, 8'hf0);
  add_vector("ssub_ew8", OP_SSUB, EW8,
    64'h01ff_7f80_0001_1002, 64'h807f_807f_00ff_20fe, 64'h807f_807f_00fe_10fc, 8'hf0);
  add_vector("minu_ew8", OP_MINU, EW8,
    64'h8001_ff00_1020_7f80, 64'h7f02_fe00_2010_8080, 64'h7f01_fe00_1010_7f80, 8'h00);
  add_vector("min_ew8", OP_MIN, EW8,
    64'h8001_ff00_1020_7f80, 64'h7f02_fe00_2010_8080, 64'h8001_fe00_1010_8080, 8'h00);
  add_vector("maxu_ew16", OP_MAXU, EW16,
    64'h8000_0001_ffff_7fff, 64'h7fff_0002_fffe_8000, 64'h8000_0002_ffff_8000, 8'h00);
  add_vector("max_ew16", OP_MAX, EW16,
    64'h8000_0001_ffff_7fff, 64'h7fff_0002_fffe_8000, 64'h7fff_0002_ffff_7fff, 8'h00);
  // Mask compares put the outcome in the element LSB
  add_vector("mseq_ew16", OP_MSEQ, EW16,
    64'h1234_0000_ffff_8000, 64'h1234_0001_ffff_0000, 64'h0001_0000_0001_0000, 8'h00);
  add_vector("msne_ew8", OP_MSNE, EW8,
    64'h0001_0203_0405_0607, 64'h0000_0202_0404_0606, 64'h0001_0001_0001_0001, 8'h00);
  add_vector("msltu_ew8", OP_MSLTU, EW8,
    64'h8001_10ff_007f_2080, 64'h7f02_1000_ff80_2080, 64'h0100_0001_0000_0000, 8'h00);
  add_vector("mslt_ew8", OP_MSLT, EW8,
    64'h8001_10ff_007f_2080, 64'h7f02_1000_ff80_2080, 64'h0000_0000_0101_0000, 8'h00);
  add_vector("msleu_ew8", OP_MSLEU, EW8,
    64'h8001_10ff_007f_2080, 64'h7f02_1000_ff80_2080, 64'h0100_0101_0000_0101, 8'h00);
  add_vector("msle_ew8", OP_MSLE, EW8,
    64'h8001_10ff_007f_2080, 64'h7f02_1000_ff80_2080, 64'h0000_0100_0101_0101, 8'h00);
  add_vector("msgtu_ew8", OP_MSGTU, EW8,
    64'h8001_10ff_007f_2080, 64'h7f02_1000_ff80_2080, 64'h0001_0000_0101_0000, 8'h00);
  add_vector("msgt_ew8", OP_MSGT, EW8,
    64'h8001_10ff_007f_2080, 64'h7f02_1000_ff80_2080, 64'h0101_0001_0000_0000, 8'h00);
  add_vector("mslt_ew32", OP_MSLT, EW32,
    64'h0000_0000_ffff_ffff, 64'hffff_ffff_0000_0000, 64'h0000_0001_0000_0000, 8'h00);
  // Shift amounts use only the low bits of a
  add_vector("sll_ew8", OP_SLL, EW8,
    64'h0901_ff00_0803_0702, 64'h01ff_8155_ff0f_01c3, 64'h02fe_8055_ff78_800c, 8'h00);
  add_vector("srl_ew16", OP_SRL, EW16,
    64'h0011_0004_000f_0000, 64'h8000_f0f0_ffff_1234, 64'h4000_0f0f_0001_1234, 8'h00);
  add_vector("sra_ew16", OP_SRA, EW16,
    64'h0011_0004_000f_0000, 64'h8000_f0f0_ffff_1234, 64'hc000_ff0f_ffff_1234, 8'h00);
endtask

`endif

// ==== sim/tb_simd_alu.sv ====
module tb_simd_alu;
  timeunit 1ns;
  timeprecision 1ps;
  import simd_alu_pkg::*;

  localparam int unsigned ResetCycles = 8;
  localparam int unsigned NumRandom   = 32;
  localparam int unsigned Latency     = 3;

  logic        clk;
  logic        rst_n;
  logic        valid;
  alu_op_e     op;
  elem_width_e vew;
  logic [63:0] opa;
  logic [63:0] opb;
  logic        out_valid;
  logic [63:0] result;
  logic [7:0]  vxsat;

  // Vector table
  string       vec_name[$];
  alu_op_e     vec_op[$];
  elem_width_e vec_vew[$];
  logic [63:0] vec_a[$];
  logic [63:0] vec_b[$];
  logic [63:0] vec_res[$];
  logic [7:0]  vec_sat[$];

  // Operations in flight, oldest first
  string       exp_name[$];
  logic [63:0] exp_res[$];
  logic [7:0]  exp_sat[$];
  int          exp_cycle[$];

  int cycle      = 0;
  int max_cycles = 1000;
  int checks     = 0;
  int errors     = 0;

  simd_alu #(
    .DataWidth (64)
  ) u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .valid_i     (valid),
    .op_i        (op),
    .vew_i       (vew),
    .operand_a_i (opa),
    .operand_b_i (opb),
    .valid_o     (out_valid),
    .result_o    (result),
    .vxsat_o     (vxsat)
  );

  task automatic add_vector(input string name, input alu_op_e op_in, input elem_width_e vew_in,
                            input logic [63:0] a, input logic [63:0] b,
                            input logic [63:0] res, input logic [7:0] sat);
    vec_name.push_back(name);
    vec_op.push_back(op_in);
    vec_vew.push_back(vew_in);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_res.push_back(res);
    vec_sat.push_back(sat);
  endtask

  `include "simd_alu_vectors.svh"

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic issue(input string name, input alu_op_e op_in, input elem_width_e vew_in,
                       input logic [63:0] a, input logic [63:0] b,
                       input logic [63:0] res, input logic [7:0] sat);
    valid = 1'b1;
    op    = op_in;
    vew   = vew_in;
    opa   = a;
    opb   = b;
    exp_name.push_back(name);
    exp_res.push_back(res);
    exp_sat.push_back(sat);
    exp_cycle.push_back(cycle);
  endtask

  task automatic retire_oldest();
    void'(exp_name.pop_front());
    void'(exp_res.pop_front());
    void'(exp_sat.pop_front());
    void'(exp_cycle.pop_front());
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Timeout
  //////////////////////////////

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycle, exp_name.size());
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      if (out_valid) begin
        errors++;
        $display("valid_o went high during reset");
      end
    end else if (out_valid) begin
      if (exp_name.size() == 0) begin
        errors++;
        $display("valid_o high with no operation in flight");
      end else begin
        check(exp_name[0], exp_res[0], result);
        check({exp_name[0], " flags"}, exp_sat[0], vxsat);
        check({exp_name[0], " latency"}, Latency, cycle - exp_cycle[0]);
        retire_oldest();
      end
    end else if (exp_name.size() != 0 && cycle - exp_cycle[0] > Latency) begin
      errors++;
      $display("valid_o never came for %s", exp_name[0]);
      retire_oldest();
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int unsigned seed;
    logic [63:0] ra;
    logic [63:0] rb;
    logic [63:0] rres;
    alu_op_e     rop;
    seed = 32'hc5011043;
    void'($urandom(seed));
    rst_n = 1'b0;
    valid = 1'b0;
    op    = OP_AND;
    vew   = EW8;
    opa   = '0;
    opb   = '0;
    load_vectors();
    max_cycles = ResetCycles + vec_name.size() + NumRandom + Latency + 20;

    repeat (ResetCycles) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int i = 0; i < vec_name.size(); i++) begin
      @(posedge clk);
      #2;
      issue(vec_name[i], vec_op[i], vec_vew[i], vec_a[i], vec_b[i], vec_res[i], vec_sat[i]);
    end

    // Random bitwise ops, width has no effect on the result
    for (int i = 0; i < NumRandom; i++) begin
      rop = alu_op_e'($urandom_range(2));
      ra  = {$urandom, $urandom};
      rb  = {$urandom, $urandom};
      case (rop)
        OP_AND:  rres = ra & rb;
        OP_OR:   rres = ra | rb;
        default: rres = ra ^ rb;
      endcase
      @(posedge clk);
      #2;
      issue($sformatf("rand_%0d", i), rop, elem_width_e'($urandom_range(3)),
            ra, rb, rres, 8'h00);
    end
    @(posedge clk);
    #2;
    valid = 1'b0;

    while (exp_name.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== simd_alu.f ====
+incdir+sim
hw/simd_alu_pkg.sv
hw/simd_alu_decode.sv
hw/simd_alu_compare.sv
hw/simd_alu_execute.sv
hw/simd_alu.sv
sim/tb_simd_alu.sv

// ==== Bender.yml ====
package:
  name: simd_alu

sources:
  - hw/simd_alu_pkg.sv
  - hw/simd_alu_decode.sv
  - hw/simd_alu_compare.sv
  - hw/simd_alu_execute.sv
  - hw/simd_alu.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_simd_alu.sv
